// ==== compile.f ====
logic/bpu_branch_pkg.sv
logic/bpu_table_pkg.sv
logic/btb_ram.sv
logic/bpu_update.sv
logic/bpu_lookup.sv
logic/bpu_top.sv
testbench/bpu_asserts.sv
testbench/bpu_tb.sv

// ==== logic/bpu_branch_pkg.sv ====
package bpu_branch_pkg;

    localparam int ADDR_WIDTH = 32;

    // instruction address or branch target, word aligned
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // two-bit direction counter
    // high bit set predicts not taken
    typedef enum logic [1:0] {
        weak_taken       = 2'b00,
        strong_taken     = 2'b01,
        weak_not_taken   = 2'b10,
        strong_not_taken = 2'b11
    } counter_t;

    // branch plus its delay slot
    localparam addr_t FALL_THROUGH_OFFSET = 32'd8;

endpackage

// ==== logic/bpu_lookup.sv ====
`timescale 1ns/1ps

module bpu_lookup
    import bpu_branch_pkg::*,
           bpu_table_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // fetch side
    input  addr_t    next_pc,
    input  logic     next_pc_valid,
    input  addr_t    fetch_pc,
    // early decode of a direct jump
    input  logic     jump_direct,
    input  addr_t    jump_target,
    input  logic     ds_allowin,
    // table read port
    output logic     rd_en,
    output index_t   rd_index,
    input  entry_t   rd_entry,
    input  logic     rd_hit_valid,
    // prediction back to the pc mux
    output addr_t    pred_target,
    output logic     pred_valid,
    // registered copy for decode
    output logic     ds_valid,
    output logic     ds_taken,
    output counter_t ds_count,
    output addr_t    ds_target
);

    logic [COUNT_WIDTH-1:0] count_raw;
    counter_t               rd_count;
    tag_t                   rd_tag;
    addr_t                  rd_target;
    tag_t                   fetch_tag;
    logic                   hit;
    logic                   not_taken_hint;
    logic                   pred_taken;

    // read the table with the address fetched next
    assign rd_en    = next_pc_valid;
    assign rd_index = next_pc[ADDR_INDEX_LSB +: INDEX_WIDTH];

    // split the entry read last cycle
    assign count_raw = rd_entry[ENTRY_COUNT_LSB +: COUNT_WIDTH];
    assign rd_count  = counter_t'(count_raw);
    assign rd_tag    = rd_entry[ENTRY_TAG_LSB +: TAG_WIDTH];
    assign rd_target = rd_entry[ENTRY_TARGET_LSB +: TARGET_WIDTH];

    // fetch_pc is the address that was read
    assign fetch_tag      = fetch_pc[ADDR_TAG_LSB +: TAG_WIDTH];
    assign hit            = rd_hit_valid && (rd_tag == fetch_tag);
    assign not_taken_hint = count_raw[1];

    assign pred_valid = hit || jump_direct;

    // a decoded jump beats the table
    always_comb begin
        if (jump_direct) begin
            pred_target = jump_target;
        end else if (not_taken_hint) begin
            pred_target = fetch_pc + FALL_THROUGH_OFFSET;  // past the delay slot
        end else begin
            pred_target = rd_target;
        end
    end

    assign pred_taken = jump_direct ? 1'b1 : ~not_taken_hint;

    // decode register, held while decode stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid  <= 1'b0;
            ds_taken  <= 1'b0;
            ds_count  <= weak_taken;
            ds_target <= '0;
        end else if (ds_allowin) begin
            if (pred_valid) begin
                ds_valid  <= 1'b1;
                ds_taken  <= pred_taken;
                ds_count  <= rd_count;
                ds_target <= pred_target;
            end else begin
                ds_valid  <= 1'b0;          // no prediction for this slot
                ds_taken  <= 1'b0;
                ds_count  <= counter_t'(2'b00);
                ds_target <= '0;
            end
        end
    end

endmodule

// ==== logic/bpu_table_pkg.sv ====
package bpu_table_pkg;

    localparam int BTB_ENTRIES  = 256;
    localparam int INDEX_WIDTH  = $clog2(BTB_ENTRIES);
    localparam int TAG_WIDTH    = 22;
    localparam int TARGET_WIDTH = 32;
    localparam int COUNT_WIDTH  = 2;
    localparam int ENTRY_WIDTH  = COUNT_WIDTH + TAG_WIDTH + TARGET_WIDTH;

    // where index and tag sit in a fetch address
    localparam int ADDR_INDEX_LSB = 2;                            // skip byte offset
    localparam int ADDR_TAG_LSB   = ADDR_INDEX_LSB + INDEX_WIDTH;

    // entry layout, counter on top and target at the bottom
    localparam int ENTRY_TARGET_LSB = 0;
    localparam int ENTRY_TAG_LSB    = ENTRY_TARGET_LSB + TARGET_WIDTH;
    localparam int ENTRY_COUNT_LSB  = ENTRY_TAG_LSB + TAG_WIDTH;

    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [ENTRY_WIDTH-1:0] entry_t;

endpackage

// ==== logic/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top
    import bpu_branch_pkg::*,
           bpu_table_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // lookup side
    input  addr_t    next_pc,
    input  logic     next_pc_valid,
    input  addr_t    fetch_pc,
    input  logic     jump_direct,
    input  addr_t    jump_target,
    input  logic     ds_allowin,
    output addr_t    pred_target,
    output logic     pred_valid,
    output logic     ds_valid,
    output logic     ds_taken,
    output counter_t ds_count,
    output addr_t    ds_target,
    // update side, from execute
    input  logic     res_is_branch,
    input  addr_t    res_pc,
    input  counter_t res_count,
    input  logic     res_taken,
    input  addr_t    res_target
);

    logic   rd_en;
    index_t rd_index;
    entry_t rd_entry;
    logic   rd_hit_valid;
    logic   wr_en;
    index_t wr_index;
    entry_t wr_entry;

    bpu_update i_bpu_update (
        .clk           (clk),
        .reset         (reset),
        .res_is_branch (res_is_branch),
        .res_pc        (res_pc),
        .res_count     (res_count),
        .res_taken     (res_taken),
        .res_target    (res_target),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_entry      (wr_entry)
    );

    bpu_lookup i_bpu_lookup (
        .clk           (clk),
        .reset         (reset),
        .next_pc       (next_pc),
        .next_pc_valid (next_pc_valid),
        .fetch_pc      (fetch_pc),
        .jump_direct   (jump_direct),
        .jump_target   (jump_target),
        .ds_allowin    (ds_allowin),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .rd_entry      (rd_entry),
        .rd_hit_valid  (rd_hit_valid),
        .pred_target   (pred_target),
        .pred_valid    (pred_valid),
        .ds_valid      (ds_valid),
        .ds_taken      (ds_taken),
        .ds_count      (ds_count),
        .ds_target     (ds_target)
    );

    btb_ram i_btb_ram (
        .clk          (clk),
        .reset        (reset),
        .rd_en        (rd_en),
        .rd_index     (rd_index),
        .rd_entry     (rd_entry),
        .rd_hit_valid (rd_hit_valid),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_entry     (wr_entry)
    );

endmodule

// ==== logic/bpu_update.sv ====
`timescale 1ns/1ps

module bpu_update
    import bpu_branch_pkg::*,
           bpu_table_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // resolved branch from execute
    input  logic     res_is_branch,
    input  addr_t    res_pc,
    input  counter_t res_count,
    input  logic     res_taken,
    input  addr_t    res_target,
    // table write port
    output logic     wr_en,
    output index_t   wr_index,
    output entry_t   wr_entry
);

    logic     res_valid_q;
    addr_t    res_pc_q;
    counter_t res_count_q;
    logic     res_taken_q;
    addr_t    res_target_q;

    counter_t count_next;
    tag_t     wr_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= res_is_branch;
        end
    end

    // payload of the result, only meaningful with res_valid_q
    always_ff @(posedge clk) begin
        res_pc_q     <= res_pc;
        res_count_q  <= res_count;
        res_taken_q  <= res_taken;
        res_target_q <= res_target;
    end

    // saturating step of the direction counter
    always_comb begin
        count_next = res_count_q;
        if (res_taken_q) begin
            case (res_count_q)
                strong_not_taken: count_next = weak_not_taken;
                weak_not_taken:   count_next = weak_taken;
                weak_taken:       count_next = strong_taken;
                strong_taken:     count_next = strong_taken;  // saturate
                default:          count_next = weak_taken;
            endcase
        end else begin
            case (res_count_q)
                strong_taken:     count_next = weak_taken;
                weak_taken:       count_next = weak_not_taken;
                weak_not_taken:   count_next = strong_not_taken;
                strong_not_taken: count_next = strong_not_taken;  // saturate
                default:          count_next = weak_not_taken;
            endcase
        end
    end

    assign wr_tag   = res_pc_q[ADDR_TAG_LSB +: TAG_WIDTH];
    assign wr_en    = res_valid_q;
    assign wr_index = res_pc_q[ADDR_INDEX_LSB +: INDEX_WIDTH];
    assign wr_entry = {count_next, wr_tag, res_target_q};  // counter, tag, target

endmodule

// ==== logic/btb_ram.sv ====
`timescale 1ns/1ps

module btb_ram
    import bpu_table_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    // read port
    input  logic   rd_en,
    input  index_t rd_index,
    output entry_t rd_entry,
    output logic   rd_hit_valid,
    // write port
    input  logic   wr_en,
    input  index_t wr_index,
    input  entry_t wr_entry
);

    entry_t                 mem [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    // storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // read data holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= mem[rd_index];  // old contents on a same-edge write
        end
    end

    // valid bits, so a cold table never hits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q      <= '0;
            rd_hit_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= 1'b1;
            end
            if (rd_en) begin
                rd_hit_valid <= valid_q[rd_index];  // read first as well
            end
        end
    end

endmodule

// ==== testbench/bpu_asserts.sv ====
`timescale 1ns/1ps

module bpu_asserts
    import bpu_branch_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     ds_allowin,
    input logic     jump_direct,
    input logic     pred_valid,
    input logic     ds_valid,
    input logic     ds_taken,
    input counter_t ds_count,
    input addr_t    ds_target
);

    int unsigned fail_count = 0;  // summed into the final count

    reset_clears_ds: assert property (@(posedge clk) reset |=> !ds_valid)
        else begin
            fail_count++;
            $error("ds_valid high in the cycle after reset");
        end

    // decode register frozen while decode stalls
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        !ds_allowin |=> $stable({ds_valid, ds_taken, ds_count, ds_target}))
        else begin
            fail_count++;
            $error("decode outputs changed while ds_allowin was low");
        end

    jump_gives_prediction: assert property (@(posedge clk) disable iff (reset)
        jump_direct |-> pred_valid)
        else begin
            fail_count++;
            $error("pred_valid low with jump_direct high");
        end

endmodule

bind bpu_lookup bpu_asserts i_bpu_asserts (.*);

// ==== testbench/bpu_tb.sv ====
`timescale 1ns/1ps

module bpu_tb
    import bpu_branch_pkg::*,
           bpu_table_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES   = 4000;

    logic     clk, reset;
    addr_t    next_pc, fetch_pc, jump_target, res_pc, res_target, pred_target, ds_target;
    logic     next_pc_valid, jump_direct, ds_allowin, res_is_branch, res_taken;
    logic     pred_valid, ds_valid, ds_taken;
    counter_t res_count, ds_count;

    // reference table, read register and pending write
    logic     tbl_valid [BTB_ENTRIES];
    counter_t tbl_count [BTB_ENTRIES];
    tag_t     tbl_tag [BTB_ENTRIES];
    addr_t    tbl_target [BTB_ENTRIES];
    logic     rd_valid, pend_en;
    counter_t rd_count, pend_count;
    tag_t     rd_tag, pend_tag;
    addr_t    rd_target, pend_target;
    index_t   pend_index;
    // expected outputs
    logic     exp_pred_valid, exp_pred_taken, exp_ds_valid, exp_ds_taken, exp_count_known;
    addr_t    exp_pred_target, exp_ds_target;
    counter_t exp_ds_count;

    counter_t    seen_count [8];  // counter decode would report, per pool pc
    logic [31:0] lfsr;
    int          errors, checks, total;

    bpu_top i_bpu_top (.*);

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            bits = {bits[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return bits;
    endfunction

    // two tags on each of four indices
    function automatic addr_t pool_pc(input logic [2:0] k);
        logic [7:0] idx;
        case (k[2:1])
            2'd0:    idx = 8'h10;
            2'd1:    idx = 8'h11;
            2'd2:    idx = 8'h7f;
            default: idx = 8'hc3;
        endcase
        return {(k[0] ? 22'h2a5c1 : 22'h00123), idx, 2'b00};
    endfunction

    // states ranked from strong not taken up to strong taken
    function automatic counter_t step_count(input counter_t c, input logic taken);
        counter_t order [4];
        int       level;
        order = '{strong_not_taken, weak_not_taken, weak_taken, strong_taken};
        level = 0;
        for (int i = 0; i < 4; i++) begin
            if (order[i] == c) level = i;
        end
        if (taken && level < 3) level++;
        else if (!taken && level > 0) level--;
        return order[level];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic predict();
        exp_pred_valid  = (rd_valid && rd_tag == fetch_pc[31:10]) || jump_direct;
        exp_pred_taken  = jump_direct || !rd_count[1];
        if (jump_direct) exp_pred_target = jump_target;
        else if (rd_count[1]) exp_pred_target = fetch_pc + 32'd8;
        else exp_pred_target = rd_target;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) tbl_valid[i] = 1'b0;
            {rd_valid, pend_en, exp_ds_valid, exp_ds_taken} = '0;
            exp_ds_count    = weak_taken;
            exp_ds_target   = '0;
            exp_count_known = 1'b1;
        end else begin
            predict();
            if (ds_allowin) begin
                exp_ds_valid    = exp_pred_valid;
                exp_ds_taken    = exp_pred_valid && exp_pred_taken;
                exp_ds_target   = exp_pred_valid ? exp_pred_target : '0;
                exp_ds_count    = exp_pred_valid ? rd_count : weak_taken;
                exp_count_known = !exp_pred_valid || rd_valid;  // unwritten entry reads as X
            end
            if (next_pc_valid) begin  // read sees the table before this edge's write
                rd_valid  = tbl_valid[next_pc[9:2]];
                rd_count  = tbl_count[next_pc[9:2]];
                rd_tag    = tbl_tag[next_pc[9:2]];
                rd_target = tbl_target[next_pc[9:2]];
            end
            if (pend_en) begin
                tbl_valid[pend_index]  = 1'b1;
                tbl_count[pend_index]  = pend_count;
                tbl_tag[pend_index]    = pend_tag;
                tbl_target[pend_index] = pend_target;
            end
            pend_en     = res_is_branch;
            pend_index  = res_pc[9:2];
            pend_tag    = res_pc[31:10];
            pend_count  = step_count(res_count, res_taken);
            pend_target = res_target;
        end
    end

    task automatic drive_inputs();
        logic [2:0] k;
        if (next_pc_valid) fetch_pc = next_pc;  // address read at the last edge
        next_pc       = pool_pc(3'(take_bits(3)));
        next_pc_valid = take_bits(3) != 0;
        jump_direct   = take_bits(3) == 0;
        jump_target   = take_bits(30) << 2;
        ds_allowin    = take_bits(2) != 0;
        res_is_branch = 1'(take_bits(1));
        k             = 3'(take_bits(3));
        res_pc        = pool_pc(k);
        res_taken     = 1'(take_bits(1));
        res_count     = seen_count[k];
        res_target    = take_bits(30) << 2;
        if (res_is_branch) seen_count[k] = step_count(seen_count[k], res_taken);
    endtask

    // entry read at the last edge against the fetch_pc driven for it
    task automatic check_prediction();
        predict();
        check_value("pred_valid", pred_valid, exp_pred_valid);
        if (exp_pred_valid) check_value("pred_target", pred_target, exp_pred_target);
    endtask

    task automatic check_decode();
        check_value("ds_valid", ds_valid, exp_ds_valid);
        check_value("ds_taken", ds_taken, exp_ds_taken);
        check_value("ds_target", ds_target, exp_ds_target);
        if (exp_count_known) check_value("ds_count", ds_count, exp_ds_count);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout: the test loop did not complete in the expected time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        lfsr   = 32'h5e0;
        errors = 0;
        checks = 0;
        reset  = 1'b1;
        {next_pc, fetch_pc, jump_target, res_pc, res_target} = '0;
        {next_pc_valid, jump_direct, ds_allowin, res_is_branch, res_taken} = '0;
        res_count = weak_not_taken;
        for (int i = 0; i < 8; i++) seen_count[i] = weak_not_taken;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_inputs();
            #(CLK_PERIOD / 4);  // fetch_pc settled, next edge still ahead
            check_prediction();
            @(negedge clk);
            check_decode();
        end
        total = errors + i_bpu_top.i_bpu_lookup.i_bpu_asserts.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d", checks, errors,
                 i_bpu_top.i_bpu_lookup.i_bpu_asserts.fail_count);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
